// ==== fetch_top.f ====
hdl/riscv_pkg.sv
hdl/frontend_pkg.sv
hdl/predecoder.sv
hdl/branch_unit.sv
hdl/address_unit.sv
hdl/register_file.sv
hdl/fetch_stage.sv
hdl/fetch_top.sv
verification/imem_model.sv
verification/fetch_top_tb.sv

// ==== hdl/address_unit.sv ====
module address_unit (
  input  frontend_pkg::agu_req_t req,
  output frontend_pkg::agu_rsp_t rsp
);

  import riscv_pkg::*;

  word_t base;
  word_t address;
  logic [1:0] offset;
  logic ctrl;
  logic mem;

  assign ctrl = req.jal | req.jalr | req.branch;
  assign mem = req.load | req.store;

  always_comb begin
    // jalr and memory accesses are register relative, the rest pc relative
    base = (req.jalr | mem) ? req.rdata1 : req.pc;
    address = base + req.imm;
    if (req.jalr) begin
      address[0] = 1'b0;
    end
    offset = address[1:0];

    rsp.address = address;
    rsp.byteenable = 4'b0000;
    if (req.lsu_op.lsu_b) begin
      rsp.byteenable = 4'b0001 << offset;
    end else if (req.lsu_op.lsu_h) begin
      rsp.byteenable = 4'b0011 << {offset[1], 1'b0};
    end else if (req.lsu_op.lsu_w) begin
      rsp.byteenable = 4'b1111;
    end

    rsp.exception = 1'b0;
    rsp.ecause = '0;
    if (ctrl && offset != 2'b00) begin
      rsp.exception = 1'b1;
      rsp.ecause = except_instr_misaligned;
    end else if (mem && ((req.lsu_op.lsu_h && offset[0]) ||
                         (req.lsu_op.lsu_w && offset != 2'b00))) begin
      rsp.exception = 1'b1;
      rsp.ecause = req.load ? except_load_misaligned : except_store_misaligned;
    end
    rsp.etval = rsp.exception ? address : '0;
  end

endmodule

// ==== hdl/branch_unit.sv ====
module branch_unit (
  input  riscv_pkg::word_t   rdata1,
  input  riscv_pkg::word_t   rdata2,
  input  riscv_pkg::bcu_op_t bcu_op,
  output logic               taken
);

  import riscv_pkg::*;

  logic eq;
  logic lt;
  logic ltu;

  assign eq = rdata1 == rdata2;
  assign lt = $signed(rdata1) < $signed(rdata2);
  assign ltu = rdata1 < rdata2;

  always_comb begin
    case (bcu_op)
      bcu_beq:  taken = eq;
      bcu_bne:  taken = ~eq;
      bcu_blt:  taken = lt;
      bcu_bge:  taken = ~lt;
      bcu_bltu: taken = ltu;
      bcu_bgeu: taken = ~ltu;
      default:  taken = 1'b0;
    endcase
  end

endmodule

// ==== hdl/fetch_stage.sv ====
module fetch_stage #(
  parameter riscv_pkg::word_t reset_vector = 32'h0000_0000
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    hold,
  input  frontend_pkg::redirect_t redirect,
  input  frontend_pkg::mem_rsp_t  imem_rsp,
  output frontend_pkg::mem_req_t  imem_req,
  output frontend_pkg::mem_req_t  dmem_req,
  input  frontend_pkg::decode_t   dec,
  output riscv_pkg::word_t        instr,
  output riscv_pkg::reg_addr_t    raddr1,
  output riscv_pkg::reg_addr_t    raddr2,
  input  riscv_pkg::word_t        rdata1,
  input  riscv_pkg::word_t        rdata2,
  output riscv_pkg::bcu_op_t      bcu_op,
  input  logic                    taken,
  output frontend_pkg::agu_req_t  agu_req,
  input  frontend_pkg::agu_rsp_t  agu_rsp,
  output frontend_pkg::fetch_out_t out
);

  import riscv_pkg::*;
  import frontend_pkg::*;

  word_t pc;
  word_t pc_next;
  logic running;
  logic fetch_ok;
  fetch_out_t v;

  // running stays low through reset and lets the first fetch out after it
  assign fetch_ok = running & ~hold & imem_rsp.ready;

  always_comb begin
    imem_req = '0;
    imem_req.valid = running & ~hold;
    imem_req.instr = 1'b1;
    imem_req.addr = pc;

    instr = imem_rsp.ready ? imem_rsp.rdata : nop_instr;
    raddr1 = dec.raddr1;
    raddr2 = dec.raddr2;
    bcu_op = dec.bcu_op;

    v = init_fetch_out;
    v.pc = pc;
    v.instr = instr;
    v.rdata1 = rdata1;
    v.rdata2 = rdata2;
    v.waddr = dec.waddr;
    if (dec.valid) begin
      v.imm = dec.imm;
      v.wren = dec.wren;
      v.rden1 = dec.rden1;
      v.rden2 = dec.rden2;
      v.lui = dec.lui;
      v.auipc = dec.auipc;
      v.jal = dec.jal;
      v.jalr = dec.jalr;
      v.branch = dec.branch;
      v.load = dec.load;
      v.store = dec.store;
      v.bcu_op = dec.bcu_op;
      v.lsu_op = dec.lsu_op;
      v.valid = 1'b1;
    end
    v.jump = v.jal | v.jalr | (v.branch & taken);

    agu_req.rdata1 = v.rdata1;
    agu_req.imm = v.imm;
    agu_req.pc = v.pc;
    agu_req.auipc = v.auipc;
    agu_req.jal = v.jal;
    agu_req.jalr = v.jalr;
    agu_req.branch = v.branch;
    agu_req.load = v.load;
    agu_req.store = v.store;
    agu_req.lsu_op = v.lsu_op;

    v.address = agu_rsp.address;
    v.byteenable = agu_rsp.byteenable;
    v.exception = agu_rsp.exception;
    v.ecause = agu_rsp.ecause;
    v.etval = agu_rsp.etval;

    if (!fetch_ok) begin
      v.wren = 1'b0;
      v.jal = 1'b0;
      v.jalr = 1'b0;
      v.branch = 1'b0;
      v.load = 1'b0;
      v.store = 1'b0;
      v.jump = 1'b0;
      v.valid = 1'b0;
    end

    // a faulting access or jump is dropped and only the trap information goes on
    if (v.exception) begin
      if (v.load) begin
        v.load = 1'b0;
        v.wren = 1'b0;
      end else if (v.store) begin
        v.store = 1'b0;
      end else if (v.jump) begin
        v.jump = 1'b0;
        v.wren = 1'b0;
      end else begin
        v.exception = 1'b0;
      end
    end

    dmem_req.valid = v.load | v.store;
    dmem_req.instr = 1'b0;
    dmem_req.addr = v.address;
    if (v.lsu_op.lsu_b) begin
      dmem_req.wdata = {4{v.rdata2[7:0]}};
    end else if (v.lsu_op.lsu_h) begin
      dmem_req.wdata = {2{v.rdata2[15:0]}};
    end else begin
      dmem_req.wdata = v.rdata2;
    end
    dmem_req.wstrb = v.store ? v.byteenable : 4'h0;

    if (redirect.valid) begin
      pc_next = redirect.target;
    end else if (v.jump) begin
      pc_next = v.address;
    end else if (fetch_ok) begin
      pc_next = pc + 32'd4;
    end else begin
      pc_next = pc;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      pc <= reset_vector;
      running <= 1'b0;
      out <= init_fetch_out;
    end else begin
      pc <= pc_next;
      running <= 1'b1;
      if (!hold) begin
        out <= v;
      end
    end
  end

endmodule

// ==== hdl/fetch_top.sv ====
module fetch_top #(
  parameter riscv_pkg::word_t reset_vector = 32'h0000_0000
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     hold,
  input  frontend_pkg::redirect_t  redirect,
  output frontend_pkg::mem_req_t   imem_req,
  input  frontend_pkg::mem_rsp_t   imem_rsp,
  output frontend_pkg::mem_req_t   dmem_req,
  input  frontend_pkg::reg_write_t reg_write,
  output frontend_pkg::fetch_out_t out
);

  import riscv_pkg::*;
  import frontend_pkg::*;

  decode_t dec;
  word_t instr;
  reg_addr_t raddr1;
  reg_addr_t raddr2;
  word_t rdata1;
  word_t rdata2;
  bcu_op_t bcu_op;
  logic taken;
  agu_req_t agu_req;
  agu_rsp_t agu_rsp;

  fetch_stage #(
    .reset_vector(reset_vector)
  ) u_fetch_stage (
    .clk(clk),
    .rst(rst),
    .hold(hold),
    .redirect(redirect),
    .imem_rsp(imem_rsp),
    .imem_req(imem_req),
    .dmem_req(dmem_req),
    .dec(dec),
    .instr(instr),
    .raddr1(raddr1),
    .raddr2(raddr2),
    .rdata1(rdata1),
    .rdata2(rdata2),
    .bcu_op(bcu_op),
    .taken(taken),
    .agu_req(agu_req),
    .agu_rsp(agu_rsp),
    .out(out)
  );

  predecoder u_predecoder (
    .instr(instr),
    .dec(dec)
  );

  branch_unit u_branch_unit (
    .rdata1(rdata1),
    .rdata2(rdata2),
    .bcu_op(bcu_op),
    .taken(taken)
  );

  address_unit u_address_unit (
    .req(agu_req),
    .rsp(agu_rsp)
  );

  register_file u_register_file (
    .clk(clk),
    .raddr1(raddr1),
    .raddr2(raddr2),
    .reg_write(reg_write),
    .rdata1(rdata1),
    .rdata2(rdata2)
  );

endmodule

// ==== hdl/frontend_pkg.sv ====
package frontend_pkg;

  import riscv_pkg::*;

  typedef struct packed {
    logic       valid;
    logic       instr;
    word_t      addr;
    word_t      wdata;
    logic [3:0] wstrb;
  } mem_req_t;

  typedef struct packed {
    logic  ready;
    word_t rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic      valid;
    word_t     imm;
    reg_addr_t waddr;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    logic      wren;
    logic      rden1;
    logic      rden2;
    logic      lui;
    logic      auipc;
    logic      jal;
    logic      jalr;
    logic      branch;
    logic      load;
    logic      store;
    bcu_op_t   bcu_op;
    lsu_op_t   lsu_op;
  } decode_t;

  typedef struct packed {
    word_t   rdata1;
    word_t   imm;
    word_t   pc;
    logic    auipc;
    logic    jal;
    logic    jalr;
    logic    branch;
    logic    load;
    logic    store;
    lsu_op_t lsu_op;
  } agu_req_t;

  typedef struct packed {
    word_t      address;
    logic [3:0] byteenable;
    logic       exception;
    ecause_t    ecause;
    word_t      etval;
  } agu_rsp_t;

  typedef struct packed {
    logic  valid;
    word_t target;
  } redirect_t;

  typedef struct packed {
    logic      wren;
    reg_addr_t waddr;
    word_t     wdata;
  } reg_write_t;

  typedef struct packed {
    word_t      pc;
    word_t      instr;
    word_t      rdata1;
    word_t      rdata2;
    word_t      imm;
    reg_addr_t  waddr;
    logic       wren;
    logic       rden1;
    logic       rden2;
    logic       lui;
    logic       auipc;
    logic       jal;
    logic       jalr;
    logic       branch;
    logic       load;
    logic       store;
    bcu_op_t    bcu_op;
    lsu_op_t    lsu_op;
    logic       jump;
    word_t      address;
    logic [3:0] byteenable;
    logic       exception;
    ecause_t    ecause;
    word_t      etval;
    logic       valid;
  } fetch_out_t;

  localparam fetch_out_t init_fetch_out = '0;

endpackage

// ==== hdl/predecoder.sv ====
module predecoder (
  input  riscv_pkg::word_t     instr,
  output frontend_pkg::decode_t dec
);

  import riscv_pkg::*;

  opcode_t opcode;
  funct3_t funct3;
  logic [6:0] funct7;
  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec = '0;
    dec.waddr = instr[11:7];
    dec.raddr1 = instr[19:15];
    dec.raddr2 = instr[24:20];

    case (opcode)
      opc_lui: begin
        dec.valid = 1'b1;
        dec.wren = 1'b1;
        dec.lui = 1'b1;
        dec.imm = imm_u;
      end
      opc_auipc: begin
        dec.valid = 1'b1;
        dec.wren = 1'b1;
        dec.auipc = 1'b1;
        dec.imm = imm_u;
      end
      opc_jal: begin
        dec.valid = 1'b1;
        dec.wren = 1'b1;
        dec.jal = 1'b1;
        dec.imm = imm_j;
      end
      opc_jalr: begin
        if (funct3 == f3_jalr) begin
          dec.valid = 1'b1;
          dec.wren = 1'b1;
          dec.rden1 = 1'b1;
          dec.jalr = 1'b1;
          dec.imm = imm_i;
        end
      end
      opc_branch: begin
        dec.imm = imm_b;
        case (funct3)
          f3_beq:  dec.bcu_op = bcu_beq;
          f3_bne:  dec.bcu_op = bcu_bne;
          f3_blt:  dec.bcu_op = bcu_blt;
          f3_bge:  dec.bcu_op = bcu_bge;
          f3_bltu: dec.bcu_op = bcu_bltu;
          f3_bgeu: dec.bcu_op = bcu_bgeu;
          default: dec.bcu_op = bcu_none;
        endcase
        dec.valid = dec.bcu_op != bcu_none;
        dec.rden1 = dec.valid;
        dec.rden2 = dec.valid;
        dec.branch = dec.valid;
      end
      opc_load: begin
        if (funct3 inside {f3_byte, f3_half, f3_word, f3_byte_u, f3_half_u}) begin
          dec.valid = 1'b1;
          dec.wren = 1'b1;
          dec.rden1 = 1'b1;
          dec.load = 1'b1;
          dec.imm = imm_i;
          dec.lsu_op.lsu_b = funct3[1:0] == f3_byte[1:0];
          dec.lsu_op.lsu_h = funct3[1:0] == f3_half[1:0];
          dec.lsu_op.lsu_w = funct3 == f3_word;
          dec.lsu_op.lsu_sext = ~funct3[2];
        end
      end
      opc_store: begin
        if (funct3 inside {f3_byte, f3_half, f3_word}) begin
          dec.valid = 1'b1;
          dec.rden1 = 1'b1;
          dec.rden2 = 1'b1;
          dec.store = 1'b1;
          dec.imm = imm_s;
          dec.lsu_op.lsu_b = funct3 == f3_byte;
          dec.lsu_op.lsu_h = funct3 == f3_half;
          dec.lsu_op.lsu_w = funct3 == f3_word;
        end
      end
      opc_op_imm: begin
        // shift immediates only allow the srai bit in funct7
        if (funct3[1:0] != 2'b01 || funct7 == 7'b0 || (funct3[2] && funct7 == 7'b0100000)) begin
          dec.valid = 1'b1;
          dec.wren = 1'b1;
          dec.rden1 = 1'b1;
          dec.imm = imm_i;
        end
      end
      opc_op: begin
        if (funct7 == 7'b0 || (funct7 == 7'b0100000 && funct3 inside {3'b000, 3'b101})) begin
          dec.valid = 1'b1;
          dec.wren = 1'b1;
          dec.rden1 = 1'b1;
          dec.rden2 = 1'b1;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== hdl/register_file.sv ====
module register_file (
  input  logic                     clk,
  input  riscv_pkg::reg_addr_t     raddr1,
  input  riscv_pkg::reg_addr_t     raddr2,
  input  frontend_pkg::reg_write_t reg_write,
  output riscv_pkg::word_t         rdata1,
  output riscv_pkg::word_t         rdata2
);

  import riscv_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (reg_write.wren && reg_write.waddr != '0) begin
      regs[reg_write.waddr] <= reg_write.wdata;
    end
  end

  // x0 is never written, so its entry is masked on read
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== hdl/riscv_pkg.sv ====
package riscv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [2:0] funct3_t;
  typedef logic [3:0] ecause_t;

  // major opcodes of the RV32I base set handled by the front end
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011
  } opcode_t;

  // bcu_none must stay first so a cleared decode means no branch
  typedef enum logic [2:0] {
    bcu_none,
    bcu_beq,
    bcu_bne,
    bcu_blt,
    bcu_bge,
    bcu_bltu,
    bcu_bgeu
  } bcu_op_t;

  typedef struct packed {
    logic lsu_b;
    logic lsu_h;
    logic lsu_w;
    logic lsu_sext;
  } lsu_op_t;

  localparam funct3_t f3_jalr = 3'b000;

  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  localparam funct3_t f3_byte   = 3'b000;
  localparam funct3_t f3_half   = 3'b001;
  localparam funct3_t f3_word   = 3'b010;
  localparam funct3_t f3_byte_u = 3'b100;
  localparam funct3_t f3_half_u = 3'b101;

  localparam ecause_t except_instr_misaligned = 4'd0;
  localparam ecause_t except_load_misaligned  = 4'd4;
  localparam ecause_t except_store_misaligned = 4'd6;

  // addi x0, x0, 0
  localparam word_t nop_instr = 32'h0000_0013;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, and pass only if the testbench printed the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module fetch_top_tb \
  -f fetch_top.f -o sim_fetch_top || exit 1
result=$(./obj_dir/sim_fetch_top)
echo "$result"
echo "$result" | grep -qx "TEST PASS" && exit 0 || exit 1

// ==== verification/fetch_top_tb.sv ====
module fetch_top_tb;

  timeunit 1ns;
  timeprecision 1ns;

  import riscv_pkg::*;
  import frontend_pkg::*;

  localparam word_t reset_vector = 32'h0000_0100;

  logic clk;
  logic rst;
  logic hold;
  redirect_t redirect;
  reg_write_t reg_write;
  mem_req_t imem_req;
  mem_rsp_t imem_rsp;
  mem_req_t dmem_req;
  fetch_out_t out;

  word_t ref_regs [32];
  word_t ref_pc;
  int hits [1:6];
  int errs [1:6];
  int exp_mode;
  int pc_test;
  word_t exp_pc;
  word_t exp_instr;
  word_t exp_etval;
  logic exp_exc;
  fetch_out_t held_out;
  logic seen_reset;
  logic first_run;
  logic want_redirect;
  logic redirect_done;
  logic timed_out;
  word_t fi;
  logic [6:0] op;
  logic [2:0] f3;
  word_t rs1v;
  word_t rs2v;
  word_t mem_addr;
  word_t st_data;
  word_t nxt;
  logic accepted;
  logic cond;
  logic [3:0] be;
  int total_hits;
  int total_errs;

  fetch_top #(
    .reset_vector(reset_vector)
  ) UUT (
    .clk(clk),
    .rst(rst),
    .hold(hold),
    .redirect(redirect),
    .imem_req(imem_req),
    .imem_rsp(imem_rsp),
    .dmem_req(dmem_req),
    .reg_write(reg_write),
    .out(out)
  );

  imem_model u_mem (
    .clk(clk),
    .req(imem_req),
    .rsp(imem_rsp)
  );

  always #50 clk = ~clk;

  function automatic word_t enc_i(logic [6:0] opc, logic [2:0] fn, logic [4:0] rd,
                                  logic [4:0] rs1, int imm);
    logic [11:0] im;
    im = imm[11:0];
    return {im, rs1, fn, rd, opc};
  endfunction

  function automatic word_t enc_s(logic [2:0] fn, logic [4:0] rs1, logic [4:0] rs2, int imm);
    logic [11:0] im;
    im = imm[11:0];
    return {im[11:5], rs2, rs1, fn, im[4:0], 7'b0100011};
  endfunction

  function automatic word_t enc_b(logic [2:0] fn, logic [4:0] rs1, logic [4:0] rs2, int imm);
    logic [12:0] im;
    im = imm[12:0];
    return {im[12], im[10:5], rs2, rs1, fn, im[4:1], im[11], 7'b1100011};
  endfunction

  function automatic word_t enc_j(logic [4:0] rd, int imm);
    logic [20:0] im;
    im = imm[20:0];
    return {im[20], im[10:1], im[11], im[19:12], rd, 7'b1101111};
  endfunction

  task automatic check(input int id, input logic ok, input string msg);
    hits[id]++;
    assert (ok) else begin
      $display("** Error at %0t ns: %s", $time, msg);
      errs[id]++;
    end
  endtask

  task automatic put_word(input word_t addr, input word_t w);
    u_mem.mem[addr[9:2]] = w;
  endtask

  task automatic write_reg(input logic [4:0] addr, input word_t val);
    @(posedge clk);
    reg_write.wren <= 1'b1;
    reg_write.waddr <= addr;
    reg_write.wdata <= val;
    ref_regs[addr] = val;
  endtask

  task automatic run_test(input int id, input string name, input int need);
    int cycles;
    cycles = 0;
    if (!timed_out) begin
      while (hits[id] < need && cycles < 3000) begin
        @(posedge clk);
        cycles++;
      end
      if (hits[id] < need) begin
        $display("timeout: test %0d (%s) reached only %0d checks", id, name, hits[id]);
        timed_out = 1'b1;
      end else begin
        $display("test %0d %s: %0d checks, %0d errors", id, name, hits[id], errs[id]);
      end
    end
  endtask

  // reference model of the next pc and of the registered bundle, one edge behind
  always @(posedge clk) begin
    if (!rst) begin
      if (seen_reset) begin
        check(1, !imem_req.valid && !dmem_req.valid, "request valid during reset");
      end
      seen_reset = 1'b1;
      first_run = 1'b1;
      ref_pc = reset_vector;
      exp_mode = 0;
      redirect <= '0;
    end else begin
      if (first_run) begin
        check(1, imem_req.addr == reset_vector && !out.valid, "wrong state after reset");
        first_run = 1'b0;
      end
      case (exp_mode)
        1: begin
          check(1, out.valid && out.pc == exp_pc && out.instr == exp_instr,
                $sformatf("out pc %h instr %h, expected %h %h", out.pc, out.instr,
                          exp_pc, exp_instr));
          if (exp_exc) begin
            check(5, out.exception && out.ecause == except_load_misaligned &&
                  out.etval == exp_etval, "misaligned load not trapped");
          end
        end
        2: check(2, !out.valid, "out valid after a not-ready fetch");
        3: check(2, out == held_out, "out changed under hold");
        default: begin
        end
      endcase
      check(pc_test, imem_req.addr == ref_pc && imem_req.instr,
            $sformatf("fetch address %h instr flag %b, expected %h 1", imem_req.addr,
                      imem_req.instr, ref_pc));
      pc_test = 1;
      if (hold) begin
        check(2, !imem_req.valid && !dmem_req.valid, "request valid under hold");
      end

      accepted = imem_req.valid && imem_rsp.ready;
      fi = imem_rsp.rdata;
      op = fi[6:0];
      f3 = fi[14:12];
      rs1v = ref_regs[fi[19:15]];
      rs2v = ref_regs[fi[24:20]];
      nxt = accepted ? ref_pc + 32'd4 : ref_pc;
      exp_exc = 1'b0;
      if (!accepted) begin
        pc_test = 2;
      end else if (op == 7'b1101111) begin
        nxt = ref_pc + {{11{fi[31]}}, fi[31], fi[19:12], fi[20], fi[30:21], 1'b0};
        pc_test = 3;
      end else if (op == 7'b1100111) begin
        nxt = (rs1v + {{20{fi[31]}}, fi[31:20]}) & ~32'd1;
        pc_test = 3;
      end else if (op == 7'b1100011) begin
        case (f3)
          3'd0: cond = rs1v == rs2v;
          3'd1: cond = rs1v != rs2v;
          3'd4: cond = $signed(rs1v) < $signed(rs2v);
          3'd5: cond = $signed(rs1v) >= $signed(rs2v);
          3'd6: cond = rs1v < rs2v;
          3'd7: cond = rs1v >= rs2v;
          default: cond = 1'b0;
        endcase
        if (cond) begin
          nxt = ref_pc + {{19{fi[31]}}, fi[31], fi[7], fi[30:25], fi[11:8], 1'b0};
        end
        pc_test = 4;
      end else if (op == 7'b0000011 || op == 7'b0100011) begin
        if (op == 7'b0000011) begin
          mem_addr = rs1v + {{20{fi[31]}}, fi[31:20]};
        end else begin
          mem_addr = rs1v + {{20{fi[31]}}, fi[31:25], fi[11:7]};
        end
        if (f3[1:0] == 2'b00) begin
          be = 4'b0001 << mem_addr[1:0];
          st_data = {4{rs2v[7:0]}};
        end else if (f3[1:0] == 2'b01) begin
          be = 4'b0011 << mem_addr[1:0];
          st_data = {2{rs2v[15:0]}};
        end else begin
          be = 4'b1111;
          st_data = rs2v;
        end
        if (f3[1:0] == 2'b10 && mem_addr[1:0] != 2'b00) begin
          check(5, !dmem_req.valid, "dmem valid on a misaligned access");
          exp_exc = op == 7'b0000011;
          exp_etval = mem_addr;
        end else begin
          check(5, dmem_req.valid && !dmem_req.instr && dmem_req.addr == mem_addr &&
                dmem_req.wstrb == ((op == 7'b0100011) ? be : 4'h0),
                $sformatf("dmem addr %h wstrb %b, expected %h %b", dmem_req.addr,
                          dmem_req.wstrb, mem_addr, be));
          if (op == 7'b0100011) begin
            check(5, dmem_req.wdata == st_data,
                  $sformatf("store data %h, expected %h", dmem_req.wdata, st_data));
          end
        end
      end

      if (hold) begin
        exp_mode = 3;
        held_out = out;
      end else if (accepted) begin
        exp_mode = 1;
        exp_pc = ref_pc;
        exp_instr = fi;
      end else begin
        exp_mode = 2;
      end

      if (redirect.valid) begin
        nxt = redirect.target;
        if (accepted && op == 7'b1101111) begin
          redirect_done = 1'b1;
          pc_test = 6;
        end
      end
      ref_pc = nxt;

      // aim the redirect at the cycle that fetches the jal at 0x140
      if (want_redirect && !redirect_done && !hold && nxt == 32'h0000_0140) begin
        redirect.valid <= 1'b1;
        redirect.target <= 32'h0000_0100;
      end else begin
        redirect <= '0;
      end
    end
  end

  initial begin
    clk = 1'b0;
    rst = 1'b0;
    hold = 1'b0;
    redirect = '0;
    reg_write = '0;
    seen_reset = 1'b0;
    first_run = 1'b0;
    want_redirect = 1'b0;
    redirect_done = 1'b0;
    timed_out = 1'b0;
    exp_mode = 0;
    pc_test = 1;
    exp_exc = 1'b0;
    for (int i = 1; i <= 6; i++) begin
      hits[i] = 0;
      errs[i] = 0;
    end
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end

    @(posedge clk);
    put_word(32'h100, enc_i(7'h13, 3'd0, 5'd0, 5'd0, 1));
    put_word(32'h104, enc_i(7'h13, 3'd0, 5'd7, 5'd0, 5));
    put_word(32'h108, enc_b(3'd0, 5'd1, 5'd4, 8));
    put_word(32'h110, enc_b(3'd1, 5'd1, 5'd4, 8));
    put_word(32'h114, enc_b(3'd4, 5'd2, 5'd1, 8));
    put_word(32'h11c, enc_b(3'd6, 5'd2, 5'd1, 8));
    put_word(32'h120, enc_b(3'd5, 5'd2, 5'd1, 8));
    put_word(32'h124, enc_b(3'd7, 5'd2, 5'd1, 8));
    put_word(32'h12c, enc_i(7'h03, 3'd2, 5'd8, 5'd1, 4));
    put_word(32'h130, enc_s(3'd1, 5'd1, 5'd3, 2));
    put_word(32'h134, enc_s(3'd0, 5'd1, 5'd3, 3));
    put_word(32'h138, enc_i(7'h03, 3'd4, 5'd9, 5'd1, 1));
    put_word(32'h13c, enc_i(7'h03, 3'd2, 5'd10, 5'd5, 0));
    put_word(32'h140, enc_j(5'd1, 32'h40));
    put_word(32'h180, enc_i(7'h67, 3'd0, 5'd0, 5'd6, 1));
    // the six conditions again with the operands swapped, so each one goes the other way
    put_word(32'h1c0, enc_b(3'd0, 5'd1, 5'd2, 8));
    put_word(32'h1c4, enc_b(3'd1, 5'd1, 5'd2, 8));
    put_word(32'h1cc, enc_b(3'd4, 5'd1, 5'd2, 8));
    put_word(32'h1d0, enc_b(3'd6, 5'd1, 5'd2, 8));
    put_word(32'h1d8, enc_b(3'd5, 5'd1, 5'd2, 8));
    put_word(32'h1e0, enc_b(3'd7, 5'd1, 5'd2, 8));
    put_word(32'h1e4, enc_j(5'd0, -228));

    write_reg(5'd1, 32'h0000_0010);
    write_reg(5'd2, 32'hffff_fff0);
    write_reg(5'd3, 32'h0000_0020);
    write_reg(5'd4, 32'h0000_0010);
    write_reg(5'd5, 32'h0000_0203);
    write_reg(5'd6, 32'h0000_01c0);
    @(posedge clk);
    reg_write <= '0;
    repeat (8) @(posedge clk);
    rst <= 1'b1;

    run_test(1, "sequential fetch", 20);
    run_test(3, "jal and jalr", 4);
    run_test(4, "branch conditions", 12);
    run_test(5, "load and store", 8);

    @(posedge clk);
    hold <= 1'b1;
    repeat (4) @(posedge clk);
    hold <= 1'b0;
    run_test(2, "not-ready and hold", 12);

    @(negedge clk);
    want_redirect = 1'b1;
    run_test(6, "redirect over jump", 1);
    want_redirect = 1'b0;

    total_hits = 0;
    total_errs = 0;
    for (int i = 1; i <= 6; i++) begin
      total_hits += hits[i];
      total_errs += errs[i];
    end
    $display("checks %0d, errors %0d", total_hits, total_errs);
    if (total_errs == 0 && !timed_out) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== verification/imem_model.sv ====
module imem_model (
  input  logic                   clk,
  input  frontend_pkg::mem_req_t req,
  output frontend_pkg::mem_rsp_t rsp
);

  timeunit 1ns;
  timeprecision 1ns;

  import riscv_pkg::*;
  import frontend_pkg::*;

  word_t mem [256];
  logic ready;
  int seed;

  // unused words hold addi x0, x0, index so every location differs
  initial begin
    seed = 32'he1bc_fbf7;
    ready = 1'b0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = {4'h0, i[7:0], 20'h00013};
    end
  end

  // roughly one cycle in four is not ready
  always @(posedge clk) begin
    ready <= ($random(seed) & 3) != 0;
  end

  assign rsp.ready = ready;
  assign rsp.rdata = mem[req.addr[9:2]];

endmodule
